// ==== source/wave_consts.svh ====
`ifndef WAVE_CONSTS_SVH
`define WAVE_CONSTS_SVH

// Frequency value and divider width
`define WAVE_FREQ_W 11

// Divider terminal count, pointer steps when reached
`define WAVE_DIV_TOP 2047

// Length start value width
`define WAVE_LEN_W 8

// Sample index over 32 nibbles
`define WAVE_PTR_W 5

// Byte address into the 16 byte wave RAM
`define WAVE_ADDR_W 4

// Width of one sample and of the output level
`define WAVE_SAMPLE_W 4

// Clock cycles per length tick
// Kept short so the length counter runs out quickly in simulation
`define WAVE_FRAME_DIV 64

`endif

// ==== source/wave_pkg.sv ====
`include "wave_consts.svh"

package wave_pkg;

    // Frequency setting and divider value
    typedef logic [`WAVE_FREQ_W-1:0] freq_t;

    // Length counter start value
    typedef logic [`WAVE_LEN_W-1:0] length_t;

    // Volume code
    // 0 mute, 1 full, 2 half, 3 quarter
    typedef logic [1:0] volume_t;

    // Wave RAM byte address
    typedef logic [`WAVE_ADDR_W-1:0] wave_addr_t;

    // Two samples per byte, high nibble plays first
    typedef logic [2*`WAVE_SAMPLE_W-1:0] wave_byte_t;

    // One sample or one output level
    typedef logic [`WAVE_SAMPLE_W-1:0] sample_t;

    // Index of the current sample
    typedef logic [`WAVE_PTR_W-1:0] wave_ptr_t;

endpackage

// ==== source/wave_ram.sv ====
`timescale 1ns/10ps
`include "wave_consts.svh"

module wave_ram (
    input  logic                    clk_pointer_inc,
    input  logic                    ram_we,
    input  wave_pkg::wave_addr_t    ram_addr,
    input  wave_pkg::wave_byte_t    ram_wdata,
    input  wave_pkg::wave_addr_t    wave_a,
    output wave_pkg::wave_byte_t    wave_d
);

    import wave_pkg::*;

    // Number of bytes in the table
    localparam int DEPTH = 1 << `WAVE_ADDR_W;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // 16 bytes, 32 four bit samples
    // Contents undefined until written
    wave_byte_t mem [0:DEPTH-1];

    // CPU write port
    // Takes effect on the edge with the strobe high
    always_ff @(posedge clk_pointer_inc) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Player read port
    ////////////////////////////////////////////////////////////

    // Asynchronous read, no output register
    // The player sees a new byte in the same cycle the pointer moves
    assign wave_d = mem[wave_a];

endmodule

// ==== source/frame_sequencer.sv ====
`timescale 1ns/10ps
`include "wave_consts.svh"

module frame_sequencer (
    input  logic clk_pointer_inc,
    input  logic start,
    output logic length_tick
);

    // Counter wide enough for one frame period
    localparam int CNT_W = $clog2(`WAVE_FRAME_DIV);

    // Last count of the period
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`WAVE_FRAME_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Free running, modulo WAVE_FRAME_DIV
    // Never touched by the channel trigger
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One cycle strobe on the last count
    // Counter sits at zero in reset, so no tick there
    assign length_tick = (cnt == CNT_LAST);

    // Tick is a single cycle pulse, the length counter relies on it
    a_tick_one_cycle : assert property (
        @(posedge clk_pointer_inc) disable iff (start)
        length_tick |=> !length_tick
    );

endmodule

// ==== source/sound_length_ctr.sv ====
`timescale 1ns/10ps

module sound_length_ctr (
    input  logic              clk_pointer_inc,
    input  logic              start,
    input  logic              length_tick,
    input  logic              trigger,
    input  logic              single,
    input  wave_pkg::length_t length,
    output logic              enable
);

    import wave_pkg::*;

    // Current length count, counts up toward all ones
    length_t cnt;

    // Overflow point of the count
    logic cnt_full;

    assign cnt_full = (cnt == '1);

    ////////////////////////////////////////////////////////////
    // Length count and channel enable
    ////////////////////////////////////////////////////////////

    // Trigger wins over a tick in the same cycle
    // Ticks only count in single mode with the channel running
    // Tick at 255 drops enable, count stays put
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            cnt    <= '0;
            enable <= 1'b0;
        end else if (trigger) begin
            cnt    <= length;
            enable <= 1'b1;
        end else if (length_tick && single && enable) begin
            if (cnt_full) begin
                enable <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // So with single set, enable falls at tick 256 - length
    // With single clear the channel plays until the next reset

    // Only a trigger can turn the channel on
    a_enable_needs_trigger : assert property (
        @(posedge clk_pointer_inc) disable iff (start)
        $rose(enable) |-> $past(trigger)
    );

endmodule

// ==== source/sound_wave.sv ====
`timescale 1ns/10ps
`include "wave_consts.svh"

module sound_wave (
    input  logic                 clk_pointer_inc,
    input  logic                 start,
    input  logic                 trigger,
    input  logic                 on,
    input  logic                 single,
    input  wave_pkg::length_t    length,
    input  logic                 length_tick,
    input  wave_pkg::volume_t    volume,
    input  wave_pkg::freq_t      frequency,
    output wave_pkg::wave_addr_t wave_a,
    input  wave_pkg::wave_byte_t wave_d,
    output wave_pkg::sample_t    level,
    output logic                 enable
);

    import wave_pkg::*;

    // Sample rate divider, counts up to the terminal count
    freq_t     divider;

    // Index of the sample being played
    wave_ptr_t pointer;

    // High on the cycle the divider overflows
    logic      advance;

    // Nibble picked from the RAM byte
    sample_t   cur_sample;

    // Sample after the volume shift
    sample_t   scaled;

    ////////////////////////////////////////////////////////////
    // Frequency divider and sample pointer
    ////////////////////////////////////////////////////////////

    assign advance = (divider == freq_t'(`WAVE_DIV_TOP));

    // Period is 2048 - frequency cycles per sample
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            divider <= '0;
        end else if (trigger || advance) begin
            divider <= frequency;
        end else begin
            divider <= divider + 1'b1;
        end
    end

    // Restart at sample 0 on trigger
    // With on low the divider keeps running but the pointer holds
    always_ff @(posedge clk_pointer_inc or posedge start) begin
        if (start) begin
            pointer <= '0;
        end else if (trigger) begin
            pointer <= '0;
        end else if (advance && on) begin
            pointer <= pointer + 1'b1;   // wraps 31 to 0
        end
    end

    ////////////////////////////////////////////////////////////
    // Sample fetch and volume
    ////////////////////////////////////////////////////////////

    // Two samples per byte
    assign wave_a = pointer[`WAVE_PTR_W-1:1];

    // High nibble on even index, low nibble on odd
    assign cur_sample = pointer[0] ? wave_d[`WAVE_SAMPLE_W-1:0]
                                   : wave_d[2*`WAVE_SAMPLE_W-1:`WAVE_SAMPLE_W];

    always_comb begin
        case (volume)
            2'd0:    scaled = '0;
            2'd1:    scaled = cur_sample;
            2'd2:    scaled = cur_sample >> 1;
            default: scaled = cur_sample >> 2;
        endcase
    end

    // Silent whenever the length counter has the channel off
    assign level = enable ? scaled : '0;

    // Length counter
    sound_length_ctr length_ctr_i (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .length_tick     (length_tick),
        .trigger         (trigger),
        .single          (single),
        .length          (length),
        .enable          (enable)
    );

    // Pointer moves only by restart or by a single step
    a_ptr_step : assert property (
        @(posedge clk_pointer_inc) disable iff (start)
        $changed(pointer) |-> ($past(trigger) && pointer == '0) ||
                              ($past(advance) && $past(on) &&
                               pointer == wave_ptr_t'($past(pointer) + 1'b1))
    );

endmodule

// ==== source/wave_channel_top.sv ====
`timescale 1ns/10ps

module wave_channel_top (
    input  logic                 clk_pointer_inc,
    input  logic                 start,
    input  logic                 on,
    input  logic                 single,
    input  wave_pkg::volume_t    volume,
    input  wave_pkg::freq_t      frequency,
    input  wave_pkg::length_t    length,
    input  logic                 trigger,
    input  logic                 ram_we,
    input  wave_pkg::wave_addr_t ram_addr,
    input  wave_pkg::wave_byte_t ram_wdata,
    output wave_pkg::sample_t    level,
    output logic                 enable
);

    import wave_pkg::*;

    // Length tick from the frame sequencer
    logic       length_tick;

    // Player read port of the wave RAM
    wave_addr_t wave_a;
    wave_byte_t wave_d;

    ////////////////////////////////////////////////////////////
    // Wave table, tick source and player
    ////////////////////////////////////////////////////////////

    wave_ram ram_i (
        .clk_pointer_inc (clk_pointer_inc),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .wave_a          (wave_a),
        .wave_d          (wave_d)
    );

    frame_sequencer frame_seq_i (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .length_tick     (length_tick)
    );

    // Level valid one edge after trigger
    sound_wave wave_i (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .trigger         (trigger),
        .on              (on),
        .single          (single),
        .length          (length),
        .length_tick     (length_tick),
        .volume          (volume),
        .frequency       (frequency),
        .wave_a          (wave_a),
        .wave_d          (wave_d),
        .level           (level),
        .enable          (enable)
    );

endmodule

// ==== verif/wave_channel_tb.sv ====
`timescale 1ns/10ps
`include "wave_consts.svh"

module wave_channel_tb;

    import wave_pkg::*;

    ////////////////////////////////////////////////////////////
    // Test lengths
    ////////////////////////////////////////////////////////////

    localparam int FAST_FREQ     = 2046;
    localparam int SLOW_FREQ     = 2040;
    localparam int VOL_FREQ      = 2044;
    localparam int PLAY_SAMPLES  = 33;
    localparam int VOL_SAMPLES   = 8;
    localparam int PAUSE_BEFORE  = 27;
    localparam int PAUSE_HOLD    = 80;
    localparam int PAUSE_AFTER   = 24;
    localparam int LEN_START     = 250;
    localparam int LEN_CYCLES    = 7 * `WAVE_FRAME_DIV + 16;
    // Ends mid table so the retrigger has a nonzero pointer to clear
    localparam int LONG_CYCLES   = 260 * `WAVE_FRAME_DIV + 11;

    // Worst case over all tests, trigger and RAM write cycles included
    localparam int TEST_CYCLES = 8 + 32 + PLAY_SAMPLES * (2 + 8) + 3 * VOL_SAMPLES * 4
                               + PAUSE_BEFORE + PAUSE_HOLD + PAUSE_AFTER + LEN_CYCLES
                               + LONG_CYCLES + PLAY_SAMPLES * 8 + 20;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 1000;

    // DUT ports
    logic       clk_pointer_inc;
    logic       start;
    logic       on;
    logic       single;
    logic       trigger;
    logic       ram_we;
    volume_t    volume;
    freq_t      frequency;
    length_t    length;
    wave_addr_t ram_addr;
    wave_byte_t ram_wdata;
    sample_t    level;
    logic       enable;

    // Shadow of the wave RAM
    wave_byte_t shadow [0:15];

    // Cycles since reset release
    int cyc;

    int    errors;
    int    checks;
    string test_name;

    // Reference model state
    int   m_ptr;
    int   m_edges;
    int   m_period;
    int   m_len;
    logic m_en;

    wave_channel_top dut_i (
        .clk_pointer_inc (clk_pointer_inc),
        .start           (start),
        .on              (on),
        .single          (single),
        .volume          (volume),
        .frequency       (frequency),
        .length          (length),
        .trigger         (trigger),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .level           (level),
        .enable          (enable)
    );

    initial begin
        clk_pointer_inc = 1'b0;
        forever #5 clk_pointer_inc = ~clk_pointer_inc;
    end

    // Free running count, lines up with the frame sequencer
    always @(posedge clk_pointer_inc) begin
        if (start) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_pointer_inc);
        $display("Simulation stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Sample k of the table, high nibble first
    function automatic int sample_of(int k);
        wave_byte_t b;
        b = shadow[(k % 32) / 2];
        return (k % 2 == 0) ? int'(b[7:4]) : int'(b[3:0]);
    endfunction

    // Volume code 0 mutes, others shift by code minus one
    function automatic int scale(int s, int vol);
        return (vol == 0) ? 0 : (s >> (vol - 1));
    endfunction

    task automatic check(string what, int expected, int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("error in %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // One clock cycle, entered and left 1 ns after a rising edge
    // Checks at the falling edge, then steps the model over the next edge
    task automatic run_cycle();
        logic on_s;
        logic single_s;
        int   exp_level;
        on_s     = on;
        single_s = single;
        @(negedge clk_pointer_inc);
        exp_level = m_en ? scale(sample_of(m_ptr), int'(volume)) : 0;
        check("enable", int'(m_en), int'(enable));
        check("level", exp_level, int'(level));
        @(posedge clk_pointer_inc);
        #1;
        m_edges++;
        // Divider period ends, pointer steps only with on set
        if (m_edges % m_period == 0 && on_s) begin
            m_ptr = (m_ptr + 1) % 32;
        end
        // Length tick sampled at this edge
        if (cyc % `WAVE_FRAME_DIV == 0 && single_s && m_en) begin
            if (m_len == 255) begin
                m_en = 1'b0;
            end else begin
                m_len++;
            end
        end
    endtask

    task automatic run_cycles(int n);
        repeat (n) run_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic write_ram(wave_addr_t addr, wave_byte_t data);
        ram_we    = 1'b1;
        ram_addr  = addr;
        ram_wdata = data;
        @(posedge clk_pointer_inc);
        #1;
        ram_we       = 1'b0;
        shadow[addr] = data;
    endtask

    // Trigger wins over a tick on the same edge
    task automatic trigger_channel(int freq, int vol, logic sgl, int len);
        frequency = freq_t'(freq);
        volume    = volume_t'(vol);
        single    = sgl;
        length    = length_t'(len);
        trigger   = 1'b1;
        @(posedge clk_pointer_inc);
        #1;
        trigger  = 1'b0;
        m_ptr    = 0;
        m_edges  = 0;
        m_period = 2048 - freq;
        m_en     = 1'b1;
        m_len    = len;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        test_name = "reset";
        repeat (3) begin
            @(negedge clk_pointer_inc);
            check("enable in reset", 0, int'(enable));
            check("level in reset", 0, int'(level));
        end
        @(posedge clk_pointer_inc);
        #1;
        start = 1'b0;
        repeat (2) begin
            @(negedge clk_pointer_inc);
            check("enable after reset", 0, int'(enable));
            check("level after reset", 0, int'(level));
            @(posedge clk_pointer_inc);
            #1;
        end
    endtask

    task automatic test_playback();
        test_name = "playback";
        for (int i = 0; i < 16; i++) begin
            write_ram(wave_addr_t'(i), wave_byte_t'($urandom()));
        end
        on = 1'b1;
        // All 32 samples and the wrap back to sample 0
        trigger_channel(FAST_FREQ, 1, 1'b0, 0);
        run_cycles(PLAY_SAMPLES * (2048 - FAST_FREQ));
        trigger_channel(SLOW_FREQ, 1, 1'b0, 0);
        run_cycles(PLAY_SAMPLES * (2048 - SLOW_FREQ));
    endtask

    task automatic test_volume();
        int codes [3];
        codes = '{0, 2, 3};
        foreach (codes[i]) begin
            test_name = $sformatf("volume %0d", codes[i]);
            trigger_channel(VOL_FREQ, codes[i], 1'b0, 0);
            run_cycles(VOL_SAMPLES * (2048 - VOL_FREQ));
        end
    endtask

    task automatic test_pause();
        test_name = "pause";
        trigger_channel(SLOW_FREQ, 1, 1'b0, 0);
        run_cycles(PAUSE_BEFORE);
        // Pointer holds, divider keeps running
        on = 1'b0;
        run_cycles(PAUSE_HOLD);
        on = 1'b1;
        run_cycles(PAUSE_AFTER);
    endtask

    task automatic test_length();
        test_name = "length";
        // Enable drops at the sixth tick after the trigger
        trigger_channel(SLOW_FREQ, 1, 1'b1, LEN_START);
        run_cycles(LEN_CYCLES);
        check("enable after expiry", 0, int'(enable));
    endtask

    task automatic test_retrigger();
        test_name = "retrigger";
        trigger_channel(FAST_FREQ, 1, 1'b0, 0);
        // Well over 256 ticks
        run_cycles(LONG_CYCLES);
        check("enable after long run", 1, int'(enable));
        trigger_channel(SLOW_FREQ, 1, 1'b0, 0);
        run_cycles(PLAY_SAMPLES * (2048 - SLOW_FREQ));
    endtask

    initial begin
        void'($urandom(87665));
        errors    = 0;
        checks    = 0;
        test_name = "none";
        start     = 1'b1;
        on        = 1'b0;
        single    = 1'b0;
        trigger   = 1'b0;
        ram_we    = 1'b0;
        volume    = '0;
        frequency = '0;
        length    = '0;
        ram_addr  = '0;
        ram_wdata = '0;
        m_ptr     = 0;
        m_edges   = 0;
        m_period  = 2048;
        m_len     = 0;
        m_en      = 1'b0;

        test_reset();
        test_playback();
        test_volume();
        test_pause();
        test_length();
        test_retrigger();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/wave_pkg.sv
source/wave_ram.sv
source/frame_sequencer.sv
source/sound_length_ctr.sv
source/sound_wave.sv
source/wave_channel_top.sv
verif/wave_channel_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module wave_channel_tb -o wave_channel_sim

output=$(./obj_dir/wave_channel_sim)
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
else
    exit 1
fi
